// File: hw/hf_reader_pkg.sv
//----------------------------------------------------------
// HF reader receive path shared types and constants
// Sample, accumulator and report widths plus the window and
// serial port timing used by the correlator and the SSP
//----------------------------------------------------------

package hf_reader_pkg;

    //----------------------------------------------------------
    // Data types
    //----------------------------------------------------------

    // One raw ADC sample of the antenna envelope, unsigned
    typedef logic [7:0] adc_sample_t;

    // Correlation accumulator
    // 32 samples of 255 on one side of the reference need 13 bits,
    // one more bit carries the sign
    typedef logic signed [13:0] corr_acc_t;

    // Report byte as the host sees it, signed
    typedef logic signed [7:0] corr_out_t;

    //----------------------------------------------------------
    // Window and serial timing
    //----------------------------------------------------------

    // One report every four subcarrier periods of 16 samples
    localparam int window_len = 64;

    // Width of the window index counter
    localparam int window_bits = 6;

    // Serial bit time in adc_clk cycles, half low and half high
    // Two bytes of 8 bits fill exactly one window at this rate
    localparam int ssp_bit_cycles = 4;

endpackage

// File: hw/carrier_hysteresis.sv
//----------------------------------------------------------
// Carrier presence detector for snoop mode
// Full-scale hysteresis on the ADC samples with a timeout
// that forces the carrier back on after a long low time
//----------------------------------------------------------

`timescale 1ns/1ns

module carrier_hysteresis #(
    parameter int unsigned hyst_timeout = 4095
) (
    input  logic                       adc_clk,
    input  logic                       rst,
    input  hf_reader_pkg::adc_sample_t adc_d,
    output logic                       carrier_on
);

    // Enough bits to count up to the timeout value
    localparam int low_bits = $clog2(hyst_timeout + 1);

    // Number of consecutive cycles the carrier has been seen low
    logic [low_bits-1:0] low_cnt;
    logic                timeout_hit;

    // The last low cycle before the forced return to high
    assign timeout_hit = (low_cnt == low_bits'(hyst_timeout - 1));

    always_ff @(posedge adc_clk)
    begin
        if (rst)
        begin
            // The reader carrier is assumed present out of reset
            carrier_on <= 1'b1;
            low_cnt    <= '0;
        end
        else if (carrier_on)
        begin
            low_cnt <= '0;
            // Only a full-scale zero counts as a modulation gap
            if (adc_d == '0)
            begin
                carrier_on <= 1'b0;
            end
        end
        else if (timeout_hit)
        begin
            // A gap this long is no reader command, so give up on it
            carrier_on <= 1'b1;
            low_cnt    <= '0;
        end
        else
        begin
            low_cnt <= low_cnt + 1'b1;
            // Full scale ends the gap, mid-scale values keep the state
            if (adc_d == '1)
            begin
                carrier_on <= 1'b1;
            end
        end
    end

endmodule

// File: hw/iq_correlator.sv
//----------------------------------------------------------
// I/Q correlator against the 847 kHz subcarrier
// Accumulates 64-sample windows and emits one signed report
// pair per window, with the carrier bit packed in snoop mode
//----------------------------------------------------------

`timescale 1ns/1ns

module iq_correlator (
    input  logic                       adc_clk,
    input  logic                       rst,
    input  hf_reader_pkg::adc_sample_t adc_d,
    input  logic                       snoop,
    input  logic                       carrier_on,
    output logic                       report_valid,
    output hf_reader_pkg::corr_out_t   corr_i,
    output hf_reader_pkg::corr_out_t   corr_q,
    output logic                       dbg
);
    import hf_reader_pkg::*;

    localparam int acc_msb   = $bits(corr_acc_t) - 1;
    localparam int out_w     = $bits(corr_out_t);
    localparam int pad_w     = $bits(corr_acc_t) - $bits(adc_sample_t);

    // Index of the current sample inside its window
    logic [window_bits-1:0] win_k;

    logic      first_k;
    logic      last_k;
    logic      mid_k;
    corr_acc_t sample_ext;
    corr_acc_t acc_i;
    corr_acc_t acc_q;
    corr_acc_t acc_i_next;
    corr_acc_t acc_q_next;

    // Carrier state captured at fixed points of the window
    logic cap_i;
    logic cap_q;

    assign first_k = (win_k == '0);
    assign last_k  = (win_k == window_bits'(window_len - 1));
    assign mid_k   = (win_k == window_bits'(window_len / 2 - 1));

    // Samples are unsigned, so widen them with zeros
    assign sample_ext = corr_acc_t'({{pad_w{1'b0}}, adc_d});

    //----------------------------------------------------------
    // Correlators
    //----------------------------------------------------------

    // I reference is a square wave of 16 samples, high for k[3] clear
    // Q is the same wave shifted by a quarter period
    always_comb
    begin
        if (first_k)
        begin
            acc_i_next = sample_ext;
            acc_q_next = sample_ext;
        end
        else
        begin
            acc_i_next = win_k[3] ? (acc_i - sample_ext) : (acc_i + sample_ext);
            acc_q_next = (win_k[3] == win_k[2]) ? (acc_q + sample_ext)
                                                : (acc_q - sample_ext);
        end
    end

    always_ff @(posedge adc_clk)
    begin
        acc_i <= acc_i_next;
        acc_q <= acc_q_next;
        if (first_k)
        begin
            cap_i <= carrier_on;
        end
        if (mid_k)
        begin
            cap_q <= carrier_on;
        end
    end

    //----------------------------------------------------------
    // Window counter and report strobe
    //----------------------------------------------------------

    always_ff @(posedge adc_clk)
    begin
        if (rst)
        begin
            win_k        <= '0;
            report_valid <= 1'b0;
        end
        else
        begin
            win_k        <= win_k + 1'b1;
            report_valid <= last_k;
        end
    end

    // The report includes the last sample of the window, taken from the
    // next-value path so that it is ready one cycle after that sample
    always_ff @(posedge adc_clk)
    begin
        if (last_k)
        begin
            if (snoop)
            begin
                // Seven bits of tag signal, lowest bit is the reader command
                corr_i <= {acc_i_next[acc_msb -: out_w - 1], cap_i};
                corr_q <= {acc_q_next[acc_msb -: out_w - 1], cap_q};
            end
            else
            begin
                corr_i <= acc_i_next[acc_msb -: out_w];
                corr_q <= acc_q_next[acc_msb -: out_w];
            end
        end
    end

    // Toggles at the subcarrier rate, handy on a scope
    assign dbg = win_k[3];

endmodule

// File: hw/ssp_serializer.sv
//----------------------------------------------------------
// SSP transmitter for the correlation reports
// Shifts each I/Q pair out MSB first with a divided clock
// and one frame pulse at the start of each byte
//----------------------------------------------------------

`timescale 1ns/1ns

module ssp_serializer (
    input  logic                     adc_clk,
    input  logic                     rst,
    input  logic                     report_valid,
    input  hf_reader_pkg::corr_out_t corr_i,
    input  hf_reader_pkg::corr_out_t corr_q,
    output logic                     ssp_clk,
    output logic                     ssp_frame,
    output logic                     ssp_din
);
    import hf_reader_pkg::*;

    localparam int phase_bits = $clog2(ssp_bit_cycles);
    localparam int byte_bits  = $clog2($bits(corr_out_t));
    localparam int pair_bits  = 2 * $bits(corr_out_t);

    // Slot counter spans one pair, the upper bits give the bit number
    logic [window_bits-1:0]            slot_cnt;
    logic [phase_bits-1:0]             phase;
    logic [window_bits-phase_bits-1:0] bit_idx;
    logic                              active;
    logic                              bit_end;

    // I byte in the upper half so that it leaves first
    logic [pair_bits-1:0] shift_q;

    assign phase   = slot_cnt[phase_bits-1:0];
    assign bit_idx = slot_cnt[window_bits-1:phase_bits];
    assign bit_end = (phase == phase_bits'(ssp_bit_cycles - 1));

    //----------------------------------------------------------
    // Slot counter
    //----------------------------------------------------------

    always_ff @(posedge adc_clk)
    begin
        if (rst)
        begin
            slot_cnt <= '0;
            active   <= 1'b0;
        end
        else if (report_valid)
        begin
            // A new pair always restarts the frame sequence
            slot_cnt <= '0;
            active   <= 1'b1;
        end
        else if (active)
        begin
            slot_cnt <= slot_cnt + 1'b1;
            // Go quiet if no further report follows this pair
            if (slot_cnt == '1)
            begin
                active <= 1'b0;
            end
        end
    end

    //----------------------------------------------------------
    // Data shift register
    //----------------------------------------------------------

    // The shift lands on the edge where ssp_clk falls, so the host
    // sees stable data two cycles before its rising sample edge
    always_ff @(posedge adc_clk)
    begin
        if (report_valid)
        begin
            shift_q <= {corr_i, corr_q};
        end
        else if (active && bit_end)
        begin
            shift_q <= {shift_q[pair_bits-2:0], 1'b0};
        end
    end

    // Low half of each bit first, then high
    assign ssp_clk = active & phase[phase_bits-1];

    // Frame marks bit 0 of the I byte and bit 0 of the Q byte
    assign ssp_frame = active & (bit_idx[byte_bits-1:0] == '0);

    assign ssp_din = active & shift_q[pair_bits-1];

endmodule

// File: hw/hf_read_rx_xcorr.sv
//----------------------------------------------------------
// HF reader receive path, top level
// Drives the carrier and sends I/Q subcarrier correlations
// of the antenna samples to the host over SSP
//----------------------------------------------------------

`timescale 1ns/1ns

module hf_read_rx_xcorr #(
    parameter int unsigned hyst_timeout = 4095
) (
    input  logic                       adc_clk,
    input  logic                       rst,
    input  logic                       carrier_clk,
    input  hf_reader_pkg::adc_sample_t adc_d,
    input  logic                       snoop,
    output logic                       pwr_hi,
    output logic                       pwr_lo,
    output logic                       pwr_oe1,
    output logic                       pwr_oe2,
    output logic                       pwr_oe3,
    output logic                       pwr_oe4,
    output logic                       ssp_clk,
    output logic                       ssp_frame,
    output logic                       ssp_din,
    output logic                       dbg
);
    import hf_reader_pkg::*;

    logic      carrier_on;
    logic      report_valid;
    corr_out_t corr_i;
    corr_out_t corr_q;

    // Carrier stays on while reading, off when only listening in
    assign pwr_hi = carrier_clk & ~snoop;

    // Low-frequency drive is not used by this mode
    assign pwr_lo  = 1'b0;
    assign pwr_oe1 = 1'b0;
    assign pwr_oe2 = 1'b0;
    assign pwr_oe3 = 1'b0;
    assign pwr_oe4 = 1'b0;

    carrier_hysteresis #(
        .hyst_timeout (hyst_timeout)
    ) u_carrier_hysteresis (
        .adc_clk    (adc_clk),
        .rst        (rst),
        .adc_d      (adc_d),
        .carrier_on (carrier_on)
    );

    iq_correlator u_iq_correlator (
        .adc_clk      (adc_clk),
        .rst          (rst),
        .adc_d        (adc_d),
        .snoop        (snoop),
        .carrier_on   (carrier_on),
        .report_valid (report_valid),
        .corr_i       (corr_i),
        .corr_q       (corr_q),
        .dbg          (dbg)
    );

    ssp_serializer u_ssp_serializer (
        .adc_clk      (adc_clk),
        .rst          (rst),
        .report_valid (report_valid),
        .corr_i       (corr_i),
        .corr_q       (corr_q),
        .ssp_clk      (ssp_clk),
        .ssp_frame    (ssp_frame),
        .ssp_din      (ssp_din)
    );

endmodule

// File: dv/hf_read_rx_xcorr_props.sv
//----------------------------------------------------------
// Timing assertions for the HF reader receive path
// SSP frame length, data change points and report period
//----------------------------------------------------------

`timescale 1ns/1ns

module hf_read_rx_xcorr_props (
    input logic adc_clk,
    input logic rst,
    input logic ssp_clk,
    input logic ssp_frame,
    input logic ssp_din,
    input logic report_valid
);

    // Cycles since the last report strobe, or since reset
    int   gap_cnt;
    logic seen_report;

    always_ff @(posedge adc_clk)
    begin
        if (rst)
        begin
            gap_cnt     <= 0;
            seen_report <= 1'b0;
        end
        else if (report_valid)
        begin
            gap_cnt     <= 0;
            seen_report <= 1'b1;
        end
        else
        begin
            gap_cnt <= gap_cnt + 1;
        end
    end

    // Frame covers exactly the four cycles of one bit
    frame_len: assert property (@(posedge adc_clk) disable iff (rst)
        $fell(ssp_frame) |-> $past(ssp_frame, 1) && $past(ssp_frame, 2) &&
                             $past(ssp_frame, 3) && $past(ssp_frame, 4) &&
                             !$past(ssp_frame, 5))
        else $error("ssp_frame was not high for exactly 4 cycles");

    // Coming out of idle the first bit appears together with the frame
    din_on_fall: assert property (@(posedge adc_clk) disable iff (rst)
        $changed(ssp_din) |-> !ssp_clk && ($past(ssp_clk) || $rose(ssp_frame)))
        else $error("ssp_din changed outside a falling ssp_clk");

    // First report after a full window from reset, then one every 64 cycles
    report_period: assert property (@(posedge adc_clk) disable iff (rst)
        report_valid |-> gap_cnt == (seen_report ? 63 : 64))
        else $error("report_valid did not repeat every 64 cycles");

endmodule

bind hf_read_rx_xcorr hf_read_rx_xcorr_props u_hf_read_rx_xcorr_props (
    .adc_clk      (adc_clk),
    .rst          (rst),
    .ssp_clk      (ssp_clk),
    .ssp_frame    (ssp_frame),
    .ssp_din      (ssp_din),
    .report_valid (report_valid)
);

// File: dv/hf_read_rx_xcorr_tb.sv
//----------------------------------------------------------
// Testbench for the HF reader receive path
// Drives ADC samples and snoop, predicts each I/Q report with
// a software model and checks the pairs captured from SSP
//----------------------------------------------------------

`timescale 1ns/1ns

module hf_read_rx_xcorr_tb;
    import hf_reader_pkg::*;

    localparam int clk_period    = 8;
    localparam int hyst_to       = 40;
    localparam int num_windows   = 17;
    // Reset, the serial tail of the last pair and some slack
    localparam int spare_windows = 5;

    // Sample pattern of one driven window
    localparam int kind_random = 0;
    localparam int kind_square = 1;
    localparam int kind_level  = 2;
    localparam int kind_gap    = 3;

    logic        adc_clk;
    logic        rst;
    logic        carrier_clk;
    adc_sample_t adc_d;
    logic        snoop;
    logic        pwr_hi;
    logic        pwr_lo;
    logic        pwr_oe1;
    logic        pwr_oe2;
    logic        pwr_oe3;
    logic        pwr_oe4;
    logic        ssp_clk;
    logic        ssp_frame;
    logic        ssp_din;
    logic        dbg;

    int seed           = 88;
    int err_count      = 0;
    int pairs_checked  = 0;
    int windows_driven = 0;

    // Reference model state, updated once per sample
    logic        ref_carrier;
    int          low_run;
    int          win_k;
    int          samples_seen;
    logic        cap_i_ref;
    logic        cap_q_ref;
    adc_sample_t win_samp [window_len];
    corr_acc_t   ref_acc_i;
    corr_acc_t   ref_acc_q;

    // Expected and captured report pairs, oldest first
    corr_out_t exp_i_q [$];
    corr_out_t exp_q_q [$];
    logic      exp_snoop_q [$];
    corr_out_t got_i_q [$];
    corr_out_t got_q_q [$];

    // SSP receiver state
    logic       prev_ssp_clk;
    int         bit_cnt;
    logic       have_i;
    logic [7:0] shift_byte;
    logic [7:0] byte_i;

    corr_out_t pop_got_i;
    corr_out_t pop_got_q;
    corr_out_t pop_exp_i;
    corr_out_t pop_exp_q;
    logic      pop_snoop;

    hf_read_rx_xcorr #(
        .hyst_timeout (hyst_to)
    ) u_hf_read_rx_xcorr (
        .adc_clk     (adc_clk),
        .rst         (rst),
        .carrier_clk (carrier_clk),
        .adc_d       (adc_d),
        .snoop       (snoop),
        .pwr_hi      (pwr_hi),
        .pwr_lo      (pwr_lo),
        .pwr_oe1     (pwr_oe1),
        .pwr_oe2     (pwr_oe2),
        .pwr_oe3     (pwr_oe3),
        .pwr_oe4     (pwr_oe4),
        .ssp_clk     (ssp_clk),
        .ssp_frame   (ssp_frame),
        .ssp_din     (ssp_din),
        .dbg         (dbg)
    );

    initial
    begin
        adc_clk = 1'b0;
        forever #(clk_period / 2) adc_clk = ~adc_clk;
    end

    //----------------------------------------------------------
    // Reference model
    //----------------------------------------------------------

    // Sum of the window against the +1/-1 square references
    function automatic corr_acc_t window_corr(input adc_sample_t samp [window_len],
                                              input bit quad);
        int   sum;
        int   k;
        logic plus;
        sum = 0;
        for (k = 0; k < window_len; k++)
        begin
            // Q leads I by a quarter of the 16-sample period
            plus = quad ? (k[3] == k[2]) : (k[3] == 1'b0);
            sum  = plus ? sum + int'(samp[k]) : sum - int'(samp[k]);
        end
        return corr_acc_t'(sum);
    endfunction

    // In snoop mode the lowest bit carries the carrier state
    function automatic corr_out_t format_report(input corr_acc_t acc, input logic sn,
                                                input logic cap);
        if (sn)
        begin
            return {acc[13:7], cap};
        end
        return acc[13:6];
    endfunction

    // Full-scale hysteresis with a forced return after hyst_to low cycles
    task automatic step_carrier(input adc_sample_t d);
        if (ref_carrier)
        begin
            low_run = 0;
            if (d == 8'd0)
            begin
                ref_carrier = 1'b0;
            end
        end
        else
        begin
            low_run++;
            if (low_run == hyst_to || d == 8'd255)
            begin
                ref_carrier = 1'b1;
                low_run     = 0;
            end
        end
    endtask

    //----------------------------------------------------------
    // Compare tasks
    //----------------------------------------------------------

    task automatic check_report(input corr_out_t got_i, input corr_out_t got_q,
                                input corr_out_t want_i, input corr_out_t want_q,
                                input string what);
        if (got_i !== want_i || got_q !== want_q)
        begin
            err_count++;
            $display("error at %0t ns: %s got I %0d Q %0d, expected I %0d Q %0d",
                     $time, what, got_i, got_q, want_i, want_q);
            $display("Simulation finished: FAIL");
            $fatal(1, "report mismatch");
        end
    endtask

    task automatic check_level(input logic got, input logic want, input string what);
        if (got !== want)
        begin
            err_count++;
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, want);
            $display("Simulation finished: FAIL");
            $fatal(1, "level mismatch");
        end
    endtask

    // Records each sample the DUT takes and predicts the report of each window
    always @(posedge adc_clk)
    begin
        if (rst)
        begin
            ref_carrier  = 1'b1;
            low_run      = 0;
            win_k        = 0;
            samples_seen = 0;
        end
        else
        begin
            // The carrier is off while snooping and follows the input otherwise
            check_level(pwr_hi, snoop ? 1'b0 : carrier_clk, "pwr_hi");
            check_level(pwr_lo | pwr_oe1 | pwr_oe2 | pwr_oe3 | pwr_oe4, 1'b0,
                        "low-frequency drive");
            check_level(dbg, win_k[3], "dbg");
            // Nothing leaves the port until the first window has been reported
            if (samples_seen <= window_len)
            begin
                check_level(ssp_clk | ssp_frame | ssp_din, 1'b0, "idle SSP lines");
            end
            win_samp[win_k] = adc_d;
            if (win_k == 0)
            begin
                cap_i_ref = ref_carrier;
            end
            if (win_k == window_len / 2 - 1)
            begin
                cap_q_ref = ref_carrier;
            end
            if (win_k == window_len - 1)
            begin
                ref_acc_i = window_corr(win_samp, 1'b0);
                ref_acc_q = window_corr(win_samp, 1'b1);
                exp_i_q.push_back(format_report(ref_acc_i, snoop, cap_i_ref));
                exp_q_q.push_back(format_report(ref_acc_q, snoop, cap_q_ref));
                exp_snoop_q.push_back(snoop);
            end
            step_carrier(adc_d);
            win_k = (win_k + 1) % window_len;
            samples_seen++;
        end
    end

    // SSP receiver, samples ssp_din in the first cycle of each high ssp_clk
    always @(posedge adc_clk)
    begin
        if (rst)
        begin
            prev_ssp_clk = 1'b0;
            bit_cnt      = 0;
            have_i       = 1'b0;
        end
        else
        begin
            if (ssp_clk && !prev_ssp_clk)
            begin
                if (ssp_frame)
                begin
                    shift_byte = {7'b0, ssp_din};
                    bit_cnt    = 1;
                end
                else if (bit_cnt > 0)
                begin
                    shift_byte = {shift_byte[6:0], ssp_din};
                    bit_cnt++;
                end
                if (bit_cnt == 8)
                begin
                    // I byte comes first, Q completes the pair
                    if (have_i)
                    begin
                        got_i_q.push_back(corr_out_t'(byte_i));
                        got_q_q.push_back(corr_out_t'(shift_byte));
                        have_i = 1'b0;
                    end
                    else
                    begin
                        byte_i = shift_byte;
                        have_i = 1'b1;
                    end
                    bit_cnt = 0;
                end
            end
            prev_ssp_clk = ssp_clk;
        end
    end

    always @(posedge adc_clk)
    begin
        if (got_q_q.size() > 0)
        begin
            if (exp_i_q.size() == 0)
            begin
                err_count++;
                $display("A report pair arrived on SSP with no window expected");
                $display("Simulation finished: FAIL");
                $fatal(1, "unexpected report");
            end
            else
            begin
                pop_got_i = got_i_q.pop_front();
                pop_got_q = got_q_q.pop_front();
                pop_exp_i = exp_i_q.pop_front();
                pop_exp_q = exp_q_q.pop_front();
                pop_snoop = exp_snoop_q.pop_front();
                if (pop_snoop)
                begin
                    check_report(corr_out_t'({pop_got_i[7:1], 1'b0}),
                                 corr_out_t'({pop_got_q[7:1], 1'b0}),
                                 corr_out_t'({pop_exp_i[7:1], 1'b0}),
                                 corr_out_t'({pop_exp_q[7:1], 1'b0}), "snoop report");
                    check_level(pop_got_i[0], pop_exp_i[0], "carrier bit at k 0");
                    check_level(pop_got_q[0], pop_exp_q[0], "carrier bit at k 31");
                end
                else
                begin
                    check_report(pop_got_i, pop_got_q, pop_exp_i, pop_exp_q, "report");
                end
                pairs_checked++;
            end
        end
    end

    //----------------------------------------------------------
    // Stimulus
    //----------------------------------------------------------

    // One window of 64 samples, each sampled by the DUT on the next edge
    task automatic drive_window(input int kind, input adc_sample_t level, input logic sn);
        adc_sample_t v;
        int          k;
        for (k = 0; k < window_len; k++)
        begin
            case (kind)
                kind_square: v = k[3] ? 8'd0 : 8'd255;
                kind_level:  v = level;
                kind_gap:    v = (k >= 16 && k < 20) ? 8'd0 : level;
                default:     v = adc_sample_t'($random(seed));
            endcase
            adc_d       <= v;
            snoop       <= sn;
            carrier_clk <= ~carrier_clk;
            @(posedge adc_clk);
        end
        windows_driven++;
    endtask

    initial
    begin
        rst         = 1'b1;
        adc_d       = '0;
        snoop       = 1'b0;
        carrier_clk = 1'b0;
        repeat (5) @(posedge adc_clk);
        rst <= 1'b0;
        repeat (3) drive_window(kind_random, 8'd0, 1'b0);
        // In phase with I, so I saturates high and Q cancels
        repeat (2) drive_window(kind_square, 8'd0, 1'b0);
        repeat (2) drive_window(kind_level, 8'd128, 1'b0);
        repeat (3) drive_window(kind_random, 8'd0, 1'b1);
        drive_window(kind_square, 8'd0, 1'b1);
        // Short zero gaps clear the carrier, the timeout brings it back
        repeat (3) drive_window(kind_gap, 8'd128, 1'b1);
        drive_window(kind_level, 8'd128, 1'b1);
        repeat (2) drive_window(kind_random, 8'd0, 1'b0);
        wait (pairs_checked >= windows_driven);
        if (err_count == 0)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial
    begin
        #((num_windows + spare_windows) * window_len * clk_period);
        $display("Timed out waiting for all report pairs to arrive on SSP");
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: sources.f
hw/hf_reader_pkg.sv
hw/carrier_hysteresis.sv
hw/iq_correlator.sv
hw/ssp_serializer.sv
hw/hf_read_rx_xcorr.sv
dv/hf_read_rx_xcorr_props.sv
dv/hf_read_rx_xcorr_tb.sv

// File: Makefile
# Verilator build and run of the HF reader receive path testbench

TOP = hf_read_rx_xcorr_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module $(TOP) -Mdir obj_dir -f sources.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
